//--- Makefile
# Verilator build and run of the tensor core testbench

VERILATOR ?= verilator
TOP       ?= tb_tensor_core
FILELIST  ?= tensor_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/operand_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module operand_feeder #(
    parameter int N = tc_pkg::TC_N
) (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                rd_valid,
    input  wire logic [N*tc_pkg::TC_ACC_W-1:0]       rd_data,
    tc_sched_if.feed                                 sched,
    output tc_pkg::op_t  [N-1:0]                     a_edge,
    output tc_pkg::op_t  [N-1:0]                     b_edge,
    output logic                                     acc_init,
    output tc_pkg::acc_t [N-1:0][N-1:0]              init_tile
);
    import tc_pkg::*;

    localparam int ROW_W  = $clog2(N);
    localparam int STEP_W = $clog2(3 * N);

    op_t                  a_tile [N][N];
    op_t                  b_tile [N][N];
    acc_t [N-1:0][N-1:0]  c_tile;
    logic [ROW_W-1:0]     beat_row;
    logic [STEP_W-1:0]    step;
    logic                 load_phase;
    op_t  [N-1:0]         a_next;
    op_t  [N-1:0]         b_next;

    assign load_phase = (sched.phase == READ_C) || (sched.phase == LOAD_A) ||
                        (sched.phase == LOAD_B);

    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_row <= '0;
        end else if (!load_phase) begin
            beat_row <= '0;
        end else if (rd_valid) begin
            beat_row <= (beat_row == ROW_W'(N - 1)) ? '0 : beat_row + 1'b1;
        end
    end

    // One beat is one row of the selected tile
    always_ff @(posedge clk) begin
        if (load_phase && rd_valid) begin
            for (int e = 0; e < N; e++) begin
                case (sched.load_mat)
                    MAT_A:   a_tile[beat_row][e] <= rd_data[e*TC_OP_W +: TC_OP_W];
                    MAT_B:   b_tile[beat_row][e] <= rd_data[e*TC_OP_W +: TC_OP_W];
                    default: c_tile[beat_row][e] <= rd_data[e*TC_ACC_W +: TC_ACC_W];
                endcase
            end
        end
    end

    // Row i of A and column i of B enter i steps late
    always_comb begin
        int s;
        int k;
        s = int'(step);
        for (int i = 0; i < N; i++) begin
            k         = s - i;
            a_next[i] = '0;
            b_next[i] = '0;
            if (sched.grid_en && k >= 0 && k < N) begin
                a_next[i] = a_tile[i][k];
                b_next[i] = b_tile[k][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            a_edge <= '0;
            b_edge <= '0;
            step   <= '0;
        end else begin
            a_edge <= a_next;
            b_edge <= b_next;
            step   <= sched.grid_en ? step + 1'b1 : '0;
        end
    end

    assign acc_init  = sched.grid_en && (step == '0);    // First compute cycle
    assign init_tile = c_tile;

endmodule

`default_nettype wire

//--- src/result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module result_drain #(
    parameter int N = tc_pkg::TC_N
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    tc_sched_if.drain                         sched,
    input  wire tc_pkg::acc_t [N-1:0][N-1:0]  acc_grid,
    input  wire logic                         out_ready,
    output logic                              out_valid,
    output logic [$clog2(N)-1:0]              out_row,
    output tc_pkg::acc_t [N-1:0]              out_data
);
    import tc_pkg::*;

    localparam int ROW_W = $clog2(N);

    acc_t [N-1:0][N-1:0] snap;

    always_ff @(posedge clk) begin
        if (sched.drain_start) begin
            snap <= acc_grid;    // Grid is final here
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid        <= 1'b0;
            out_row          <= '0;
            sched.drain_done <= 1'b0;
        end else begin
            sched.drain_done <= 1'b0;
            if (sched.drain_start) begin
                out_valid <= 1'b1;
                out_row   <= '0;
            end else if (out_valid && out_ready) begin
                if (out_row == ROW_W'(N - 1)) begin
                    out_valid        <= 1'b0;
                    sched.drain_done <= 1'b1;
                end else begin
                    out_row <= out_row + 1'b1;
                end
            end
        end
    end

    assign out_data = snap[out_row];

    a_out_stable: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_row));

endmodule

`default_nettype wire

//--- src/systolic_pe.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_pe (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire tc_pkg::op_t   a_in,
    input  wire tc_pkg::op_t   b_in,
    input  wire logic          init,
    input  wire tc_pkg::acc_t  init_val,
    output tc_pkg::op_t        a_out,
    output tc_pkg::op_t        b_out,
    output tc_pkg::acc_t       acc
);
    import tc_pkg::*;

    logic signed [2*TC_OP_W-1:0] prod;

    assign prod = a_in * b_in;

    // Operands move one PE per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            a_out <= '0;
            b_out <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    always_ff @(posedge clk) begin
        if (init) begin
            acc <= init_val;
        end else begin
            acc <= acc + acc_t'(prod);    // Wraps at 32 bits
        end
    end

endmodule

`default_nettype wire

//--- src/tc_pkg.sv
`default_nettype none

package tc_pkg;

    localparam int TC_N       = 4;
    localparam int TC_OP_W    = 8;
    localparam int TC_ACC_W   = 32;
    localparam int TC_ADDR_W  = 32;
    localparam int TC_BEATS_W = 6;

    // Fixed tile locations in external memory
    localparam logic [TC_ADDR_W-1:0] TC_BASE_C = 32'h0001_0000;
    localparam logic [TC_ADDR_W-1:0] TC_BASE_A = 32'h0010_0000;
    localparam logic [TC_ADDR_W-1:0] TC_BASE_B = 32'h0100_0000;

    typedef enum logic [1:0] {
        MAT_C,
        MAT_A,
        MAT_B
    } mat_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B,
        SYSTOLIC,
        WRITE_BACK,
        FINISH
    } phase_t;

    typedef logic signed [TC_ACC_W-1:0] acc_t;
    typedef logic signed [TC_OP_W-1:0]  op_t;

endpackage

`default_nettype wire

//--- src/tc_sched_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tc_sched_if #(
    parameter int N = tc_pkg::TC_N
) (
    input wire logic clk,
    input wire logic rst
);
    import tc_pkg::*;

    phase_t phase;
    mat_t   load_mat;     // Tile being loaded
    logic   grid_en;
    logic   drain_start;
    logic   drain_done;

    modport seq   (output phase, load_mat, grid_en, drain_start, input drain_done);
    modport feed  (input phase, load_mat, grid_en);
    modport drain (input drain_start, output drain_done);

    // Compute window is exactly 3N-1 cycles
    a_grid_window: assert property (@(posedge clk) disable iff (!rst)
        $fell(grid_en) |-> $past(grid_en, 3*N-1) && !$past(grid_en, 3*N));

endinterface

`default_nettype wire

//--- src/tc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tc_sequencer #(
    parameter int N = tc_pkg::TC_N
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire logic                          req_ready,
    input  wire logic                          rd_valid,
    input  wire logic                          rd_last,
    output logic                               req_valid,
    output tc_pkg::mat_t                       req_mat,
    output logic [tc_pkg::TC_ADDR_W-1:0]       req_base,
    output logic [tc_pkg::TC_BEATS_W-1:0]      req_beats,
    output logic                               done,
    tc_sched_if.seq                            sched
);
    import tc_pkg::*;

    localparam int SYS_LAST = 3 * N - 2;
    localparam int CNT_W    = $clog2(3 * N);

    phase_t           phase;
    logic             req_sent;     // Request of this phase already accepted
    logic [CNT_W-1:0] sys_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase             <= IDLE;
            req_valid         <= 1'b0;
            req_sent          <= 1'b0;
            sys_cnt           <= '0;
            sched.drain_start <= 1'b0;
        end else begin
            sched.drain_start <= 1'b0;
            case (phase)
                IDLE, FINISH: begin
                    if (start) begin
                        phase <= READ_C;
                    end
                end
                READ_C, LOAD_A, LOAD_B: begin
                    if (req_valid && req_ready) begin
                        req_valid <= 1'b0;
                        req_sent  <= 1'b1;
                    end else if (!req_sent) begin
                        req_valid <= 1'b1;    // Hold until accepted
                    end
                    if (rd_valid && rd_last) begin
                        req_sent <= 1'b0;
                        case (phase)
                            READ_C:  phase <= LOAD_A;
                            LOAD_A:  phase <= LOAD_B;
                            default: phase <= SYSTOLIC;
                        endcase
                    end
                end
                SYSTOLIC: begin
                    if (sys_cnt == CNT_W'(SYS_LAST)) begin
                        sys_cnt           <= '0;
                        phase             <= WRITE_BACK;
                        sched.drain_start <= 1'b1;
                    end else begin
                        sys_cnt <= sys_cnt + 1'b1;
                    end
                end
                WRITE_BACK: begin
                    if (sched.drain_done) begin
                        phase <= FINISH;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (phase)
            LOAD_A: begin
                req_mat  = MAT_A;
                req_base = TC_BASE_A;
            end
            LOAD_B: begin
                req_mat  = MAT_B;
                req_base = TC_BASE_B;
            end
            default: begin
                req_mat  = MAT_C;
                req_base = TC_BASE_C;
            end
        endcase
    end

    assign req_beats      = TC_BEATS_W'(N - 1);    // N beats per tile
    assign done           = (phase == FINISH);
    assign sched.phase    = phase;
    assign sched.load_mat = req_mat;
    assign sched.grid_en  = (phase == SYSTOLIC);

    a_req_hold: assert property (@(posedge clk) disable iff (!rst)
        req_valid && !req_ready |=> req_valid);

endmodule

`default_nettype wire

//--- src/tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core #(
    parameter int N = tc_pkg::TC_N
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              start,
    output logic                                   req_valid,
    output tc_pkg::mat_t                           req_mat,
    output logic [tc_pkg::TC_ADDR_W-1:0]           req_base,
    output logic [tc_pkg::TC_BEATS_W-1:0]          req_beats,
    input  wire logic                              req_ready,
    input  wire logic                              rd_valid,
    input  wire logic [N*tc_pkg::TC_ACC_W-1:0]     rd_data,
    input  wire logic                              rd_last,
    output logic                                   out_valid,
    output logic [$clog2(N)-1:0]                   out_row,
    output tc_pkg::acc_t [N-1:0]                   out_data,
    input  wire logic                              out_ready,
    output logic                                   done
);
    import tc_pkg::*;

    op_t  [N-1:0]         a_edge;
    op_t  [N-1:0]         b_edge;
    logic                 acc_init;
    acc_t [N-1:0][N-1:0]  init_tile;
    acc_t [N-1:0][N-1:0]  acc_grid;
    op_t                  a_h [N][N+1];    // Column 0 is the left edge
    op_t                  b_v [N+1][N];    // Row 0 is the top edge

    tc_sched_if #(.N(N)) sched (.clk(clk), .rst(rst));

    tc_sequencer #(.N(N)) u_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .req_ready (req_ready),
        .rd_valid  (rd_valid),
        .rd_last   (rd_last),
        .req_valid (req_valid),
        .req_mat   (req_mat),
        .req_base  (req_base),
        .req_beats (req_beats),
        .done      (done),
        .sched     (sched.seq)
    );

    operand_feeder #(.N(N)) u_feed (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .sched     (sched.feed),
        .a_edge    (a_edge),
        .b_edge    (b_edge),
        .acc_init  (acc_init),
        .init_tile (init_tile)
    );

    for (genvar r = 0; r < N; r++) begin : g_row
        assign a_h[r][0] = a_edge[r];
        assign b_v[0][r] = b_edge[r];
        for (genvar c = 0; c < N; c++) begin : g_col
            systolic_pe u_pe (
                .clk      (clk),
                .rst      (rst),
                .a_in     (a_h[r][c]),
                .b_in     (b_v[r][c]),
                .init     (acc_init),
                .init_val (init_tile[r][c]),
                .a_out    (a_h[r][c+1]),
                .b_out    (b_v[r+1][c]),
                .acc      (acc_grid[r][c])
            );
        end
    end

    result_drain #(.N(N)) u_drain (
        .clk       (clk),
        .rst       (rst),
        .sched     (sched.drain),
        .acc_grid  (acc_grid),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- tensor_core.f
src/tc_pkg.sv
src/tc_sched_if.sv
src/systolic_pe.sv
src/tc_sequencer.sv
src/operand_feeder.sv
src/result_drain.sv
src/tensor_core.sv
testbench/tb_tensor_core.sv

//--- testbench/tb_tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_core;
    import tc_pkg::*;

    localparam int N         = 4;
    localparam int ROW_W     = $clog2(N);
    localparam int DATA_W    = N * TC_ACC_W;
    localparam int CLK_NS    = 4;
    localparam int NUM_RUNS  = 7;
    localparam int RUN_LIMIT = 200 * N;    // Cycles allowed per run

    localparam int KIND_RANDOM  = 0;
    localparam int KIND_SMALL   = 1;
    localparam int KIND_EXTREME = 2;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       start;
    logic                       req_valid;
    mat_t                       req_mat;
    logic [TC_ADDR_W-1:0]       req_base;
    logic [TC_BEATS_W-1:0]      req_beats;
    logic                       req_ready;
    logic                       rd_valid;
    logic [DATA_W-1:0]          rd_data;
    logic                       rd_last;
    logic                       out_valid;
    logic [ROW_W-1:0]           out_row;
    acc_t [N-1:0]               out_data;
    logic                       out_ready;
    logic                       done;

    op_t  a_mem [N][N];
    op_t  b_mem [N][N];
    acc_t c_mem [N][N];
    acc_t exp_d [N][N];    // Model result D = C + A x B
    int   errors;
    int   checks;
    int   tests;

    tensor_core #(.N(N)) dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .req_valid (req_valid),
        .req_mat   (req_mat),
        .req_base  (req_base),
        .req_beats (req_beats),
        .req_ready (req_ready),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_last   (rd_last),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_data  (out_data),
        .out_ready (out_ready),
        .done      (done)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_mat(input string name, input mat_t got, input mat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_row(input string name, input logic [ROW_W-1:0] got,
                             input logic [ROW_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_field(input string name, input logic [TC_ADDR_W-1:0] got,
                               input logic [TC_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic void fill_tiles(input int kind);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                case (kind)
                    KIND_SMALL: begin
                        a_mem[r][c] = op_t'(int'($urandom % 16) - 8);
                        b_mem[r][c] = op_t'(int'($urandom % 16) - 8);
                        c_mem[r][c] = '0;
                    end
                    KIND_EXTREME: begin
                        a_mem[r][c] = ($urandom % 2 == 0) ? op_t'(-128) : op_t'(127);
                        b_mem[r][c] = ($urandom % 2 == 0) ? op_t'(-128) : op_t'(127);
                        // Close enough to either limit that the sum wraps
                        c_mem[r][c] = ($urandom % 2 == 0) ?
                                      acc_t'(32'h7FFF_FFF0 - $urandom % 256) :
                                      acc_t'(32'h8000_0010 + $urandom % 256);
                    end
                    default: begin
                        a_mem[r][c] = op_t'($urandom);
                        b_mem[r][c] = op_t'($urandom);
                        c_mem[r][c] = acc_t'($urandom);
                    end
                endcase
            end
        end
    endfunction

    function automatic void compute_model();
        acc_t sum;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                sum = c_mem[r][c];
                for (int k = 0; k < N; k++) begin
                    sum = sum + acc_t'(a_mem[r][k]) * acc_t'(b_mem[k][c]);
                end
                exp_d[r][c] = sum;
            end
        end
    endfunction

    function automatic logic [DATA_W-1:0] beat_data(input mat_t mat, input int row);
        logic [DATA_W-1:0] d;
        d = '0;
        for (int e = 0; e < N; e++) begin
            case (mat)
                MAT_A:   d[e*TC_OP_W +: TC_OP_W] = a_mem[row][e];
                MAT_B:   d[e*TC_OP_W +: TC_OP_W] = b_mem[row][e];
                default: d[e*TC_ACC_W +: TC_ACC_W] = c_mem[row][e];
            endcase
        end
        return d;
    endfunction

    // Memory side of one tile request
    task automatic serve_request(input mat_t exp_mat, input logic [TC_ADDR_W-1:0] exp_base);
        int   delay;
        int   gap;
        bit   accepted;
        mat_t served;
        delay    = int'($urandom % 4);
        accepted = 1'b0;
        served   = exp_mat;
        while (!accepted) begin
            if (req_valid && delay == 0) begin
                check_mat("req_mat", req_mat, exp_mat);
                check_field("req_base", req_base, exp_base);
                check_field("req_beats", TC_ADDR_W'(req_beats), TC_ADDR_W'(N - 1));
                served    = req_mat;
                req_ready = 1'b1;
                accepted  = 1'b1;
            end else if (req_valid) begin
                delay--;
            end
            @(posedge clk);
            #1;
        end
        req_ready = 1'b0;
        for (int row = 0; row < N; row++) begin
            gap = int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            rd_valid = 1'b1;
            rd_data  = beat_data(served, row);
            rd_last  = (row == N - 1);
            @(posedge clk);
            #1;
            rd_valid = 1'b0;
            rd_last  = 1'b0;
            rd_data  = '0;
        end
    endtask

    task automatic collect_rows(input int ready_pct);
        int rows;
        rows = 0;
        while (rows < N) begin
            if (done) begin
                report_error("done is high before all rows transferred");
            end
            out_ready = ($urandom % 100) < ready_pct;
            if (out_valid && out_ready) begin    // Transfer at the next edge
                check_row("out_row", out_row, ROW_W'(rows));
                for (int c = 0; c < N; c++) begin
                    check_acc($sformatf("out_data[%0d]", c), out_data[c], exp_d[rows][c]);
                end
                rows++;
            end
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < 20) begin
            if (out_valid) begin
                report_error("a row is offered after the last row transferred");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            report_error("done did not rise after the last row");
        end
    endtask

    task automatic run_once(input int kind, input int ready_pct);
        fill_tiles(kind);
        compute_model();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        fork
            begin
                serve_request(MAT_C, TC_BASE_C);
                serve_request(MAT_A, TC_BASE_A);
                serve_request(MAT_B, TC_BASE_B);
            end
            collect_rows(ready_pct);
        join
        wait_done();
    endtask

    task automatic run_test(input string name, input int kind, input int ready_pct,
                            input int runs);
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < runs; i++) begin
            run_once(kind, ready_pct);
        end
        tests++;
        if (errors == errors_before) begin
            $display("Test %-18s ok", name);
        end else begin
            $display("Test %-18s %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        void'($urandom(80650));
        rst       = 1'b0;
        start     = 1'b0;
        req_ready = 1'b0;
        rd_valid  = 1'b0;
        rd_data   = '0;
        rd_last   = 1'b0;
        out_ready = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;
        if (done !== 1'b0 || req_valid !== 1'b0 || out_valid !== 1'b0) begin
            report_error("outputs are not idle after reset");
        end
        run_test("request order", KIND_RANDOM, 80, 1);
        run_test("basic product", KIND_SMALL, 80, 1);
        run_test("accumulate onto C", KIND_RANDOM, 80, 1);
        run_test("extreme operands", KIND_EXTREME, 80, 1);
        run_test("back-pressure", KIND_RANDOM, 25, 1);
        run_test("back-to-back", KIND_RANDOM, 60, 2);
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_RUNS * RUN_LIMIT + 20) * CLK_NS);
        $display("Timeout: the runs did not finish within %0d cycles",
                 NUM_RUNS * RUN_LIMIT + 20);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
